// ==== source/stamofu_config.svh ====
`ifndef STAMOFU_CONFIG_SVH
`define STAMOFU_CONFIG_SVH

// ------------------------------
// address widths
// ------------------------------
`define STAMOFU_VPN_WIDTH 20
`define STAMOFU_PPN_WIDTH 22
// page offset and physical address, both in words
`define STAMOFU_PO_WORD_WIDTH 10
`define STAMOFU_PA_WORD_WIDTH 32

// ------------------------------
// dcache geometry
// ------------------------------
`define STAMOFU_DCACHE_TAG_WIDTH 22
`define STAMOFU_DCACHE_INDEX_WIDTH 6
// bank select bit inside the word address
`define STAMOFU_DCACHE_BANK_BIT 3
`define STAMOFU_DCACHE_OFFSET_WIDTH 5
`define STAMOFU_DCACHE_WAYS 2

// queue and rob sizing
`define STAMOFU_CQ_INDEX_WIDTH 3
`define STAMOFU_ROB_INDEX_WIDTH 7

`define STAMOFU_OP_LR_W 2

`endif

// ==== source/stamofu_pkg.sv ====
`include "stamofu_config.svh"

package stamofu_pkg;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [`STAMOFU_VPN_WIDTH-1:0]           vpn_t;
    typedef logic [`STAMOFU_PPN_WIDTH-1:0]           ppn_t;
    typedef logic [`STAMOFU_PO_WORD_WIDTH-1:0]       po_word_t;
    typedef logic [`STAMOFU_PA_WORD_WIDTH-1:0]       pa_word_t;
    typedef logic [`STAMOFU_DCACHE_TAG_WIDTH-1:0]    dcache_tag_t;
    typedef logic [`STAMOFU_DCACHE_INDEX_WIDTH-1:0]  dcache_index_t;
    typedef logic [`STAMOFU_DCACHE_OFFSET_WIDTH-1:0] block_offset_t;
    typedef logic [`STAMOFU_CQ_INDEX_WIDTH-1:0]      cq_index_t;
    typedef logic [`STAMOFU_ROB_INDEX_WIDTH-1:0]     rob_index_t;
    typedef logic [3:0]                              byte_mask_t;
    typedef logic [31:0]                             word_t;
    typedef logic [3:0]                              amo_op_t;

    // ------------------------------
    // request side
    // ------------------------------
    typedef struct packed {
        logic is_store; logic is_amo; logic is_fence; amo_op_t op;
        logic misaligned; logic misaligned_exception;
        vpn_t vpn; po_word_t po_word; byte_mask_t byte_mask;
        word_t write_data; cq_index_t cq_index;
    } stamofu_req_t;

    // pipeline register between REQ and RESP
    typedef struct packed {
        logic valid; logic is_amo; logic is_fence;
        logic misaligned; logic misaligned_exception;
        vpn_t vpn; po_word_t po_word; byte_mask_t byte_mask;
        word_t write_data; cq_index_t cq_index;
        logic exclusive; logic prefetch;
    } resp_stage_t;

    // ------------------------------
    // tlb and dcache
    // ------------------------------
    typedef struct packed { vpn_t vpn; cq_index_t cq_index; } dtlb_req_t;

    typedef struct packed {
        logic hit; ppn_t ppn; logic is_mem; logic page_fault; logic access_fault;
    } dtlb_resp_t;

    typedef struct packed {
        block_offset_t block_offset; dcache_index_t index; cq_index_t cq_index;
    } dcache_req_t;

    typedef struct packed {
        logic [`STAMOFU_DCACHE_WAYS-1:0]        valid_by_way;
        logic [`STAMOFU_DCACHE_WAYS-1:0]        exclusive_by_way;
        dcache_tag_t [`STAMOFU_DCACHE_WAYS-1:0] tag_by_way;
    } dcache_resp_t;

    typedef struct packed {
        logic hit_valid; logic hit_exclusive; logic hit_way;
        logic miss_valid; logic miss_exclusive; dcache_tag_t miss_tag;
    } dcache_fb_t;

    // processing to output side
    typedef struct packed { logic translated; pa_word_t return_pa_word; } resolved_t;

    // ------------------------------
    // central queue, cam, acquire
    // ------------------------------
    typedef struct packed {
        logic mem_aq; logic io_aq; logic mem_rl; logic io_rl; rob_index_t rob_index;
    } cq_grab_t;

    typedef struct packed {
        logic valid; pa_word_t pa_word; byte_mask_t byte_mask;
        word_t write_data; rob_index_t rob_index; cq_index_t cq_index;
    } cam_launch_t;

    typedef struct packed {
        logic valid; cq_index_t cq_index;
        logic dtlb_hit; logic page_fault; logic access_fault; logic is_mem;
        logic mem_aq; logic io_aq; logic mem_rl; logic io_rl;
        logic misaligned; logic misaligned_exception;
        pa_word_t pa_word; byte_mask_t byte_mask; word_t data;
    } cq_ret_t;

    typedef struct packed {
        logic valid; logic mem_aq; logic io_aq; rob_index_t rob_index;
    } aq_update_t;

endpackage

// ==== source/stamofu_req_stage.sv ====
`timescale 1ns/1ps

`include "stamofu_config.svh"

module stamofu_req_stage
    import stamofu_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,

    // central queue issue
    input  logic         req_valid,
    input  stamofu_req_t req,
    output logic         req_ack,

    // dtlb request
    output logic         dtlb_req_valid,
    output dtlb_req_t    dtlb_req,
    input  logic         dtlb_req_ready,

    // dcache prefetch request
    output logic         dcache_req_valid,
    output dcache_req_t  dcache_req,
    input  logic         dcache_req_ready,

    // to RESP stage
    output resp_stage_t  resp_stage
);

    logic is_lr_w;
    logic skip_dtlb;
    logic wants_dcache;

    // ------------------------------
    // accept and request
    // ------------------------------

    assign is_lr_w = req.is_amo & (req.op == amo_op_t'(`STAMOFU_OP_LR_W));

    // fences and misaligned exceptions never translate
    assign skip_dtlb = req.is_fence | req.misaligned_exception;

    // prefetch only stores and LR.W
    assign wants_dcache = ~skip_dtlb & (~req.is_amo | is_lr_w);

    assign req_ack = req_valid & (dtlb_req_ready | skip_dtlb);

    assign dtlb_req_valid = req_ack & ~skip_dtlb;
    assign dtlb_req.vpn = req.vpn;
    assign dtlb_req.cq_index = req.cq_index;

    assign dcache_req_valid = req_ack & wants_dcache;
    // word offset in block, byte bits zero
    assign dcache_req.block_offset = {req.po_word[`STAMOFU_DCACHE_BANK_BIT-1:0], 2'b00};
    // index sits above the bank bit, bank itself is implied
    assign dcache_req.index = req.po_word[`STAMOFU_DCACHE_BANK_BIT+1 +:
        `STAMOFU_DCACHE_INDEX_WIDTH];
    assign dcache_req.cq_index = req.cq_index;

    // ------------------------------
    // REQ to RESP register
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            resp_stage <= '0;
            resp_stage.exclusive <= 1'b1;
        end else begin
            resp_stage.valid <= req_ack;
            resp_stage.is_amo <= req.is_amo;
            resp_stage.is_fence <= req.is_fence;
            resp_stage.misaligned <= req.misaligned;
            resp_stage.misaligned_exception <= req.misaligned_exception;
            resp_stage.vpn <= req.vpn;
            resp_stage.po_word <= req.po_word;
            resp_stage.byte_mask <= req.byte_mask;
            resp_stage.write_data <= req.write_data;
            resp_stage.cq_index <= req.cq_index;
            // only LR.W may hit a shared line
            resp_stage.exclusive <= ~is_lr_w;
            resp_stage.prefetch <= wants_dcache & dcache_req_ready;
        end
    end

endmodule

// ==== source/stamofu_addr_resolve.sv ====
`timescale 1ns/1ps

`include "stamofu_config.svh"

module stamofu_addr_resolve
    import stamofu_pkg::*;
(
    // pipeline register
    input  resp_stage_t  resp_stage,

    // responses one cycle after request
    input  dtlb_resp_t   dtlb_resp,
    input  dcache_resp_t dcache_resp,

    // prefetch feedback to dcache
    output dcache_fb_t   dcache_fb,

    // to output side
    output resolved_t    resolved
);

    localparam int PAD_WIDTH =
        `STAMOFU_PA_WORD_WIDTH - `STAMOFU_VPN_WIDTH - `STAMOFU_PO_WORD_WIDTH;

    pa_word_t                         pa_word;
    dcache_tag_t                      tag;
    logic                             fault;
    logic                             use_vpn;
    logic                             lookup;
    logic [`STAMOFU_DCACHE_WAYS-1:0]  match_by_way;
    logic                             any_match;

    // ------------------------------
    // physical address
    // ------------------------------

    assign pa_word = {dtlb_resp.ppn, resp_stage.po_word};
    assign tag = pa_word[`STAMOFU_PA_WORD_WIDTH-1 -: `STAMOFU_DCACHE_TAG_WIDTH];

    assign fault = dtlb_resp.page_fault | dtlb_resp.access_fault;
    assign resolved.translated = dtlb_resp.hit & ~fault;

    // fence and exception paths hand back the virtual address
    assign use_vpn = resp_stage.is_fence | fault | resp_stage.misaligned_exception;
    assign resolved.return_pa_word = use_vpn ?
        {{PAD_WIDTH{1'b0}}, resp_stage.vpn, resp_stage.po_word} : pa_word;

    // ------------------------------
    // tag compare
    // ------------------------------

    always_comb begin
        for (int w = 0; w < `STAMOFU_DCACHE_WAYS; w++) begin
            match_by_way[w] = dcache_resp.valid_by_way[w]
                & (dcache_resp.tag_by_way[w] == tag)
                & (dcache_resp.exclusive_by_way[w] | ~resp_stage.exclusive);
        end
    end

    assign any_match = |match_by_way;
    assign lookup = resp_stage.valid & resp_stage.prefetch & resolved.translated;

    assign dcache_fb.hit_valid = lookup & any_match;
    assign dcache_fb.hit_exclusive = resp_stage.exclusive;
    // two ways, so the way number is just the way 1 match
    assign dcache_fb.hit_way = match_by_way[1];
    assign dcache_fb.miss_valid = lookup & ~any_match;
    assign dcache_fb.miss_exclusive = resp_stage.exclusive;
    assign dcache_fb.miss_tag = tag;

endmodule

// ==== source/stamofu_result_route.sv ====
`timescale 1ns/1ps

module stamofu_result_route
    import stamofu_pkg::*;
(
    input  resp_stage_t resp_stage,
    input  dtlb_resp_t  dtlb_resp,
    input  resolved_t   resolved,

    // central queue info grab, answered same cycle
    output cq_index_t   cq_grab_cq_index,
    input  cq_grab_t    cq_grab,

    // outputs
    output cam_launch_t cam_launch,
    output cq_ret_t     cq_ret,
    output aq_update_t  aq_update
);

    logic amo_known;
    logic mem_keep;
    logic io_keep;

    assign cq_grab_cq_index = resp_stage.cq_index;

    // ------------------------------
    // aq/rl masking
    // ------------------------------

    // AMO with a translation knows mem vs io
    assign amo_known = resp_stage.is_amo & dtlb_resp.hit;
    assign mem_keep = ~amo_known | dtlb_resp.is_mem;
    assign io_keep = ~amo_known | ~dtlb_resp.is_mem;

    // ------------------------------
    // cam launch
    // ------------------------------

    assign cam_launch.valid = resp_stage.valid & resolved.translated
        & ~resp_stage.is_fence & ~resp_stage.misaligned_exception;
    assign cam_launch.pa_word = resolved.return_pa_word;
    assign cam_launch.byte_mask = resp_stage.byte_mask;
    assign cam_launch.write_data = resp_stage.write_data;
    assign cam_launch.rob_index = cq_grab.rob_index;
    assign cam_launch.cq_index = resp_stage.cq_index;

    // central queue return, every valid op
    assign cq_ret.valid = resp_stage.valid;
    assign cq_ret.cq_index = resp_stage.cq_index;
    assign cq_ret.dtlb_hit = dtlb_resp.hit;
    assign cq_ret.page_fault = dtlb_resp.page_fault;
    assign cq_ret.access_fault = dtlb_resp.access_fault;
    assign cq_ret.is_mem = dtlb_resp.is_mem;
    assign cq_ret.mem_aq = cq_grab.mem_aq & mem_keep;
    assign cq_ret.io_aq = cq_grab.io_aq & io_keep;
    assign cq_ret.mem_rl = cq_grab.mem_rl & mem_keep;
    assign cq_ret.io_rl = cq_grab.io_rl & io_keep;
    assign cq_ret.misaligned = resp_stage.misaligned;
    assign cq_ret.misaligned_exception = resp_stage.misaligned_exception;
    assign cq_ret.pa_word = resolved.return_pa_word;
    assign cq_ret.byte_mask = resp_stage.byte_mask;
    assign cq_ret.data = resp_stage.write_data;

    // acquire update
    assign aq_update.valid = resp_stage.valid & amo_known;
    assign aq_update.mem_aq = cq_grab.mem_aq & dtlb_resp.is_mem;
    assign aq_update.io_aq = cq_grab.io_aq & ~dtlb_resp.is_mem;
    assign aq_update.rob_index = cq_grab.rob_index;

endmodule

// ==== source/stamofu_launch_top.sv ====
`timescale 1ns/1ps

module stamofu_launch_top
    import stamofu_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,

    // central queue issue
    input  logic         req_valid,
    input  stamofu_req_t req,
    output logic         req_ack,

    // dtlb
    output logic         dtlb_req_valid,
    output dtlb_req_t    dtlb_req,
    input  logic         dtlb_req_ready,
    input  dtlb_resp_t   dtlb_resp,

    // dcache
    output logic         dcache_req_valid,
    output dcache_req_t  dcache_req,
    input  logic         dcache_req_ready,
    input  dcache_resp_t dcache_resp,
    output dcache_fb_t   dcache_fb,

    // results
    output cam_launch_t  cam_launch,
    output cq_index_t    cq_grab_cq_index,
    input  cq_grab_t     cq_grab,
    output cq_ret_t      cq_ret,
    output aq_update_t   aq_update
);

    resp_stage_t resp_stage;
    resolved_t   resolved;

    stamofu_req_stage u_req_stage (
        .CLK(CLK), .nRST(nRST),
        .req_valid(req_valid), .req(req), .req_ack(req_ack),
        .dtlb_req_valid(dtlb_req_valid), .dtlb_req(dtlb_req), .dtlb_req_ready(dtlb_req_ready),
        .dcache_req_valid(dcache_req_valid), .dcache_req(dcache_req),
        .dcache_req_ready(dcache_req_ready),
        .resp_stage(resp_stage)
    );

    stamofu_addr_resolve u_addr_resolve (
        .resp_stage(resp_stage), .dtlb_resp(dtlb_resp), .dcache_resp(dcache_resp),
        .dcache_fb(dcache_fb), .resolved(resolved)
    );

    stamofu_result_route u_result_route (
        .resp_stage(resp_stage), .dtlb_resp(dtlb_resp), .resolved(resolved),
        .cq_grab_cq_index(cq_grab_cq_index), .cq_grab(cq_grab),
        .cam_launch(cam_launch), .cq_ret(cq_ret), .aq_update(aq_update)
    );

endmodule

// ==== bench/stamofu_sva.sv ====
`timescale 1ns/1ps

module stamofu_sva
    import stamofu_pkg::*;
(
    input logic        CLK,
    input logic        nRST,
    input logic        req_ack,
    input logic        dtlb_req_valid,
    input dcache_fb_t  dcache_fb,
    input cam_launch_t cam_launch,
    input cq_ret_t     cq_ret,
    input aq_update_t  aq_update
);

    // prefetch feedback is a hit or a miss, never both
    no_hit_and_miss: assert property (@(posedge CLK) disable iff (!nRST)
        !(dcache_fb.hit_valid && dcache_fb.miss_valid))
        else $error("dcache feedback shows hit and miss in the same cycle");

    tlb_req_needs_ack: assert property (@(posedge CLK) disable iff (!nRST)
        dtlb_req_valid |-> req_ack)
        else $error("dtlb request issued without req_ack");

    cam_implies_ret: assert property (@(posedge CLK) disable iff (!nRST)
        cam_launch.valid |-> cq_ret.valid)
        else $error("cam launch without a central queue return");

    // RESP stage is still empty in the first cycle out of reset
    quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !(cq_ret.valid || cam_launch.valid || aq_update.valid
            || dcache_fb.hit_valid || dcache_fb.miss_valid))
        else $error("valid output in the first cycle after reset");

endmodule

bind stamofu_launch_top stamofu_sva u_sva (
    .CLK(CLK), .nRST(nRST), .req_ack(req_ack), .dtlb_req_valid(dtlb_req_valid),
    .dcache_fb(dcache_fb), .cam_launch(cam_launch), .cq_ret(cq_ret), .aq_update(aq_update)
);

// ==== bench/stamofu_tb.sv ====
`timescale 1ns/1ps

`include "stamofu_config.svh"

module stamofu_tb
    import stamofu_pkg::*;
();

    localparam ppn_t PPN_XOR = 22'h2A5A5A;
    localparam int ACK_TIMEOUT = 16;
    localparam int STREAM_LEN = 24;
    localparam int STREAM_TIMEOUT = 100;

    logic         CLK = 1'b0;
    logic         nRST;
    logic         req_valid;
    stamofu_req_t req;
    logic         req_ack;
    logic         dtlb_req_valid;
    dtlb_req_t    dtlb_req;
    logic         dtlb_req_ready;
    dtlb_resp_t   dtlb_resp = '0;
    logic         dcache_req_valid;
    dcache_req_t  dcache_req;
    logic         dcache_req_ready;
    dcache_resp_t dcache_resp = '0;
    dcache_fb_t   dcache_fb;
    cam_launch_t  cam_launch;
    cq_index_t    cq_grab_cq_index;
    cq_grab_t     cq_grab;
    cq_ret_t      cq_ret;
    aq_update_t   aq_update;

    // cache contents and fault injection set by the tests
    logic [1:0]  way_valid;
    logic [1:0]  way_excl;
    dcache_tag_t way_tag0;
    dcache_tag_t way_tag1;
    logic        inject_fault;
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          tests;

    stamofu_launch_top UUT (.*);

    always #4 CLK = ~CLK;

    // ------------------------------
    // models and expected values
    // ------------------------------
    function automatic ppn_t exp_ppn(input vpn_t v);
        return ppn_t'(v) ^ PPN_XOR;
    endfunction

    function automatic rob_index_t rob_for(input cq_index_t idx);
        return {4'b1010, idx};
    endfunction

    always @(posedge CLK) begin
        if (dtlb_req_valid) begin
            dtlb_resp <= '{hit: 1'b1, ppn: exp_ppn(dtlb_req.vpn), is_mem: dtlb_req.vpn[0],
                page_fault: inject_fault, access_fault: 1'b0};
        end else begin
            dtlb_resp <= '0;
        end
    end

    always @(posedge CLK) begin
        if (dcache_req_valid) begin
            dcache_resp.valid_by_way <= way_valid;
            dcache_resp.exclusive_by_way <= way_excl;
            dcache_resp.tag_by_way[0] <= way_tag0;
            dcache_resp.tag_by_way[1] <= way_tag1;
        end else begin
            dcache_resp <= '0;
        end
    end

    // central queue answers the grab in the same cycle
    always_comb begin
        cq_grab = '{mem_aq: 1'b1, io_aq: 1'b1, mem_rl: 1'b1, io_rl: 1'b1,
            rob_index: rob_for(cq_grab_cq_index)};
    end

    function automatic dcache_fb_t exp_fb(input logic hit, input logic excl,
            input logic way, input dcache_tag_t tag);
        return '{hit_valid: hit, hit_exclusive: excl, hit_way: way, miss_valid: ~hit,
            miss_exclusive: excl, miss_tag: tag};
    endfunction

    // AMOs with a translation keep only the aq/rl bits of their space
    function automatic cq_ret_t exp_ret(input stamofu_req_t r, input logic hit,
            input logic pf, input pa_word_t word);
        logic mem;
        logic keep_mem;
        logic keep_io;
        mem = hit & r.vpn[0];
        keep_mem = ~(r.is_amo & hit) | mem;
        keep_io = ~(r.is_amo & hit) | ~mem;
        return '{valid: 1'b1, cq_index: r.cq_index, dtlb_hit: hit, page_fault: pf,
            access_fault: 1'b0, is_mem: mem, mem_aq: keep_mem, io_aq: keep_io,
            mem_rl: keep_mem, io_rl: keep_io, misaligned: r.misaligned,
            misaligned_exception: r.misaligned_exception, pa_word: word,
            byte_mask: r.byte_mask, data: r.write_data};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_store(input cq_index_t idx, output stamofu_req_t r);
        logic [31:0] bits;
        r = '0;
        r.is_store = 1'b1;
        take_bits(20, bits);
        r.vpn = bits[19:0];
        take_bits(10, bits);
        r.po_word = bits[9:0];
        take_bits(4, bits);
        r.byte_mask = bits[3:0];
        take_bits(32, bits);
        r.write_data = bits;
        r.cq_index = idx;
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_pa_word(input string name, input pa_word_t exp, input pa_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cq_ret(input string name, input cq_ret_t exp, input cq_ret_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_dcache_fb(input string name, input dcache_fb_t exp,
            input dcache_fb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_aq_update(input string name, input aq_update_t exp,
            input aq_update_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cam_launch(input string name, input cam_launch_t exp,
            input cam_launch_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_dtlb_req(input string name, input dtlb_req_t exp,
            input dtlb_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_dcache_req(input string name, input dcache_req_t exp,
            input dcache_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // drives one op and returns in the cycle its results show
    task automatic issue_op(input stamofu_req_t r, output logic tlb_req,
            output logic cache_req);
        int waited;
        logic [11:0] byte_off;
        dtlb_req_t exp_tlb;
        dcache_req_t exp_cache;
        waited = 0;
        // byte address in the page, bank bit is byte bit 5
        byte_off = {r.po_word, 2'b00};
        exp_tlb.vpn = r.vpn;
        exp_tlb.cq_index = r.cq_index;
        exp_cache.block_offset = byte_off[4:0];
        exp_cache.index = byte_off[11:6];
        exp_cache.cq_index = r.cq_index;
        @(posedge CLK);
        req_valid <= 1'b1;
        req <= r;
        @(negedge CLK);
        while (!req_ack && waited < ACK_TIMEOUT) begin
            waited++;
            @(negedge CLK);
        end
        if (!req_ack) begin
            errors++;
            $display("timeout: op with cq_index %0d was never acknowledged", r.cq_index);
        end
        tlb_req = dtlb_req_valid;
        cache_req = dcache_req_valid;
        if (dtlb_req_valid)
            check_dtlb_req("issue_op dtlb_req", exp_tlb, dtlb_req);
        if (dcache_req_valid)
            check_dcache_req("issue_op dcache_req", exp_cache, dcache_req);
        @(posedge CLK);
        req_valid <= 1'b0;
        @(negedge CLK);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic store_hit();
        stamofu_req_t r;
        cam_launch_t exp_cam;
        ppn_t ppn;
        logic tlb;
        logic cache;
        int e0;
        e0 = errors;
        random_store(3'd1, r);
        ppn = exp_ppn(r.vpn);
        way_valid = 2'b11;
        way_excl = 2'b11;
        way_tag0 = ~ppn;
        way_tag1 = ppn;
        issue_op(r, tlb, cache);
        check_flag("store_hit cache request", 1'b1, cache);
        check_dcache_fb("store_hit fb", exp_fb(1'b1, 1'b1, 1'b1, ppn), dcache_fb);
        exp_cam = '{valid: 1'b1, pa_word: {ppn, r.po_word}, byte_mask: r.byte_mask,
            write_data: r.write_data, rob_index: rob_for(r.cq_index), cq_index: r.cq_index};
        check_cam_launch("store_hit cam_launch", exp_cam, cam_launch);
        check_pa_word("store_hit cam pa_word", {ppn, r.po_word}, cam_launch.pa_word);
        check_cq_ret("store_hit cq_ret", exp_ret(r, 1'b1, 1'b0, {ppn, r.po_word}), cq_ret);
        check_flag("store_hit aq_update valid", 1'b0, aq_update.valid);
        report_test("store_hit", e0);
    endtask

    task automatic backpressure_fence();
        stamofu_req_t st;
        stamofu_req_t fence;
        logic tlb;
        logic cache;
        int e0;
        e0 = errors;
        random_store(3'd2, st);
        fence = st;
        fence.is_store = 1'b0;
        fence.is_fence = 1'b1;
        fence.cq_index = 3'd3;
        @(posedge CLK);
        dtlb_req_ready <= 1'b0;
        req_valid <= 1'b1;
        req <= st;
        for (int c = 0; c < 3; c++) begin
            @(negedge CLK);
            check_flag("backpressure ack", 1'b0, req_ack);
            check_flag("backpressure resp valid", 1'b0, cq_ret.valid);
        end
        issue_op(fence, tlb, cache);
        check_flag("fence tlb request", 1'b0, tlb);
        check_flag("fence cache request", 1'b0, cache);
        check_cq_ret("fence cq_ret", exp_ret(fence, 1'b0, 1'b0,
            {2'b00, fence.vpn, fence.po_word}), cq_ret);
        check_flag("fence cam valid", 1'b0, cam_launch.valid);
        check_flag("fence hit valid", 1'b0, dcache_fb.hit_valid);
        check_flag("fence miss valid", 1'b0, dcache_fb.miss_valid);
        @(posedge CLK);
        dtlb_req_ready <= 1'b1;
        report_test("backpressure_fence", e0);
    endtask

    task automatic amo_vs_lr_w();
        stamofu_req_t r;
        ppn_t ppn;
        logic tlb;
        logic cache;
        int e0;
        e0 = errors;
        random_store(3'd4, r);
        r.is_store = 1'b0;
        r.is_amo = 1'b1;
        r.op = 4'h1;
        issue_op(r, tlb, cache);
        check_flag("amo tlb request", 1'b1, tlb);
        check_flag("amo cache request", 1'b0, cache);
        check_aq_update("amo aq_update", '{valid: 1'b1, mem_aq: r.vpn[0], io_aq: ~r.vpn[0],
            rob_index: rob_for(r.cq_index)}, aq_update);
        check_cq_ret("amo cq_ret", exp_ret(r, 1'b1, 1'b0, {exp_ppn(r.vpn), r.po_word}), cq_ret);
        // LR.W may hit a line held shared
        random_store(3'd5, r);
        r.is_store = 1'b0;
        r.is_amo = 1'b1;
        r.op = amo_op_t'(`STAMOFU_OP_LR_W);
        ppn = exp_ppn(r.vpn);
        way_valid = 2'b01;
        way_excl = 2'b00;
        way_tag0 = ppn;
        way_tag1 = ~ppn;
        issue_op(r, tlb, cache);
        check_flag("lr_w cache request", 1'b1, cache);
        check_dcache_fb("lr_w fb", exp_fb(1'b1, 1'b0, 1'b0, ppn), dcache_fb);
        report_test("amo_vs_lr_w", e0);
    endtask

    task automatic fault_return();
        stamofu_req_t r;
        logic tlb;
        logic cache;
        int e0;
        e0 = errors;
        random_store(3'd6, r);
        // tags would hit if the translation were good
        way_valid = 2'b11;
        way_excl = 2'b11;
        way_tag0 = exp_ppn(r.vpn);
        way_tag1 = exp_ppn(r.vpn);
        inject_fault = 1'b1;
        issue_op(r, tlb, cache);
        inject_fault = 1'b0;
        check_cq_ret("fault cq_ret", exp_ret(r, 1'b1, 1'b1, {2'b00, r.vpn, r.po_word}), cq_ret);
        check_flag("fault cam valid", 1'b0, cam_launch.valid);
        check_flag("fault hit valid", 1'b0, dcache_fb.hit_valid);
        check_flag("fault miss valid", 1'b0, dcache_fb.miss_valid);
        report_test("fault_return", e0);
    endtask

    task automatic random_stream();
        stamofu_req_t r;
        stamofu_req_t pending[$];
        logic expect_result;
        int sent;
        int done;
        int cycles;
        int e0;
        e0 = errors;
        sent = 0;
        done = 0;
        cycles = 0;
        expect_result = 1'b0;
        // tags starting 2'b01 never match a ppn starting 2'b10
        way_valid = 2'b11;
        way_excl = 2'b11;
        way_tag0 = 22'h155555;
        way_tag1 = 22'h1AAAAA;
        random_store(3'd0, r);
        @(posedge CLK);
        req_valid <= 1'b1;
        req <= r;
        while (done < STREAM_LEN && cycles < STREAM_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            check_flag("stream result valid", expect_result, cq_ret.valid);
            if (cq_ret.valid && pending.size() > 0) begin
                check_cq_ret("stream cq_ret", exp_ret(pending[0], 1'b1, 1'b0,
                    {exp_ppn(pending[0].vpn), pending[0].po_word}), cq_ret);
                check_dcache_fb("stream fb", exp_fb(1'b0, 1'b1, 1'b0,
                    exp_ppn(pending[0].vpn)), dcache_fb);
                void'(pending.pop_front());
                done++;
            end
            expect_result = req_valid && req_ack;
            if (expect_result) begin
                pending.push_back(r);
                sent++;
                random_store(cq_index_t'(sent), r);
            end
            @(posedge CLK);
            if (sent < STREAM_LEN)
                req <= r;
            else
                req_valid <= 1'b0;
        end
        if (done < STREAM_LEN) begin
            errors++;
            $display("timeout: only %0d of %0d stream stores completed", done, STREAM_LEN);
        end
        report_test("random_stream", e0);
    endtask

    initial begin
        nRST = 1'b0;
        req_valid = 1'b0;
        req = '0;
        dtlb_req_ready = 1'b1;
        dcache_req_ready = 1'b1;
        way_valid = '0;
        way_excl = '0;
        way_tag0 = '0;
        way_tag1 = '0;
        inject_fault = 1'b0;
        lfsr = 16'd20345;
        errors = 0;
        checks = 0;
        tests = 0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        store_hit();
        backpressure_fence();
        amo_vs_lr_w();
        fault_return();
        random_stream();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/stamofu_pkg.sv
source/stamofu_req_stage.sv
source/stamofu_addr_resolve.sv
source/stamofu_result_route.sv
source/stamofu_launch_top.sv
bench/stamofu_sva.sv
bench/stamofu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = stamofu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
